// ==== Bender.yml ====
package:
  name: i2c_init

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/i2c_init_pkg.sv
      - rtl/init_rom.sv
      - rtl/delay_timer.sv
      - rtl/i2c_cmd_stage.sv
      - rtl/init_sequencer.sv
      - rtl/i2c_init.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_i2c_init.sv

// ==== rtl/delay_timer.sv ====
/*
 * loadable down-counter for table delay entries
 */

`timescale 1ns/1ps

`include "i2c_init_settings.svh"

module delay_timer import i2c_init_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       load_delay,
    input  delay_exp_t delay_exp,
    output logic       delay_active
);

    delay_count_t count;

    assign delay_active = (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load_delay) begin
            // 2**(base + d) cycles
            count <= delay_count_t'(1) << (`I2C_INIT_DELAY_BASE + delay_exp);
        end else if (delay_active) begin
            count <= count - 1'b1;
        end
    end

    // sequencer must be stalled for the whole delay
    a_no_reload: assert property (
        @(posedge clk) disable iff (rst)
        load_delay |-> !delay_active
    );

endmodule

// ==== rtl/i2c_cmd_stage.sv ====
/*
 * output registers for the command and data streams
 * strobe-loaded, held under back-pressure until the handshake
 */

`timescale 1ns/1ps

module i2c_cmd_stage import i2c_init_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      set_address,
    input  dev_addr_t address,
    input  logic      send_write,
    input  byte_t     wdata,
    input  logic      send_stop,
    output i2c_cmd_t  cmd,
    output logic      cmd_valid,
    input  logic      cmd_ready,
    output byte_t     data,
    output logic      data_valid,
    input  logic      data_ready,
    output logic      pending
);

    logic cmd_fire;
    logic data_fire;

    assign cmd_fire  = cmd_valid & cmd_ready;
    assign data_fire = data_valid & data_ready;

    // sequencer waits on this
    assign pending = cmd_valid | data_valid;

    // flags and valids
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd.start  <= 1'b0;
            cmd.write  <= 1'b0;
            cmd.stop   <= 1'b0;
            cmd_valid  <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            if (cmd_fire) begin
                cmd.start <= 1'b0;
                cmd.write <= 1'b0;
                cmd.stop  <= 1'b0;
                cmd_valid <= 1'b0;
            end
            if (data_fire) begin
                data_valid <= 1'b0;
            end
            // start rides along with the next write
            if (set_address) begin
                cmd.start <= 1'b1;
            end
            if (send_write) begin
                cmd.write  <= 1'b1;
                cmd.stop   <= 1'b0;
                cmd_valid  <= 1'b1;
                data_valid <= 1'b1;
            end
            if (send_stop) begin
                cmd.start <= 1'b0;
                cmd.write <= 1'b0;
                cmd.stop  <= 1'b1;
                cmd_valid <= 1'b1;
            end
        end
    end

    // payload, address kept across commands
    always_ff @(posedge clk) begin
        if (set_address) begin
            cmd.address <= address;
        end
        if (send_write) begin
            data <= wdata;
        end
    end

    a_cmd_hold: assert property (
        @(posedge clk) disable iff (rst)
        (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd))
    );

    a_data_hold: assert property (
        @(posedge clk) disable iff (rst)
        (data_valid && !data_ready) |=> (data_valid && $stable(data))
    );

    // one command in flight at a time
    a_no_strobe_pending: assert property (
        @(posedge clk) disable iff (rst)
        (set_address || send_write || send_stop) |-> !pending
    );

endmodule

// ==== rtl/i2c_init.sv ====
/*
 * power-on i2c initialiser top level
 * table rom, sequencer, delay timer and output stage
 */

`timescale 1ns/1ps

module i2c_init import i2c_init_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    output i2c_cmd_t cmd,
    output logic     cmd_valid,
    input  logic     cmd_ready,
    output byte_t    data,
    output logic     data_valid,
    input  logic     data_ready,
    output logic     busy
);

    rom_addr_t  rom_addr;
    rom_word_t  rom_data;
    logic       pending;
    logic       delay_active;
    logic       set_address;
    dev_addr_t  address;
    logic       send_write;
    byte_t      wdata;
    logic       send_stop;
    logic       load_delay;
    delay_exp_t delay_exp;

    init_rom u_init_rom (
        .clk      (clk),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    init_sequencer u_init_sequencer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .rom_data     (rom_data),
        .rom_addr     (rom_addr),
        .pending      (pending),
        .delay_active (delay_active),
        .set_address  (set_address),
        .address      (address),
        .send_write   (send_write),
        .wdata        (wdata),
        .send_stop    (send_stop),
        .load_delay   (load_delay),
        .delay_exp    (delay_exp),
        .busy         (busy)
    );

    delay_timer u_delay_timer (
        .clk          (clk),
        .rst          (rst),
        .load_delay   (load_delay),
        .delay_exp    (delay_exp),
        .delay_active (delay_active)
    );

    i2c_cmd_stage u_i2c_cmd_stage (
        .clk         (clk),
        .rst         (rst),
        .set_address (set_address),
        .address     (address),
        .send_write  (send_write),
        .wdata       (wdata),
        .send_stop   (send_stop),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .data        (data),
        .data_valid  (data_valid),
        .data_ready  (data_ready),
        .pending     (pending)
    );

endmodule

// ==== rtl/i2c_init_pkg.sv ====
/*
 * shared types for the i2c initialiser
 * vector typedefs, command struct, sequencer states, table word builders
 */

`include "i2c_init_settings.svh"

package i2c_init_pkg;

    typedef logic [6:0]                     dev_addr_t;
    typedef logic [7:0]                     byte_t;
    typedef logic [8:0]                     rom_word_t;
    typedef logic [`I2C_INIT_ROM_AW-1:0]   rom_addr_t;
    typedef logic [3:0]                     delay_exp_t;
    typedef logic [`I2C_INIT_DELAY_W-1:0]  delay_count_t;

    // command beat towards the i2c master
    typedef struct packed {
        dev_addr_t address;
        logic      start;
        logic      write;
        logic      stop;
    } i2c_cmd_t;

    typedef enum logic [0:0] {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

    // table word prefixes
    localparam logic [1:0] OP_ADDR  = 2'b01;
    localparam logic [4:0] OP_DELAY = 5'b00001;

    // whole-word codes
    localparam rom_word_t CMD_TERM_STOP  = 9'h000;
    localparam rom_word_t CMD_SEND_STOP  = 9'h041;
    // data block start of the multi-device mode, decoded as invalid here
    localparam rom_word_t CMD_DATA_BLOCK = 9'h009;

    function automatic rom_word_t rom_start_write(input dev_addr_t a);
        return {OP_ADDR, a};
    endfunction

    function automatic rom_word_t rom_write_data(input byte_t b);
        return {1'b1, b};
    endfunction

    function automatic rom_word_t rom_delay(input delay_exp_t d);
        return {OP_DELAY, d};
    endfunction

endpackage

// ==== rtl/i2c_init_settings.svh ====
/*
 * table geometry and delay timer sizing for the i2c initialiser
 * table depth, table address width, delay exponent base, counter width
 */

`ifndef I2C_INIT_SETTINGS_SVH
`define I2C_INIT_SETTINGS_SVH

// number of entries in the command table
`define I2C_INIT_ROM_DEPTH 12

// table index width, enough for the depth above
`define I2C_INIT_ROM_AW 4

// delay entries wait 2**(base + d) cycles
`define I2C_INIT_DELAY_BASE 16

// delay counter width
// must hold 2**(base + 15) for the largest exponent
`define I2C_INIT_DELAY_W 32

`endif

// ==== rtl/init_rom.sv ====
/*
 * fixed power-on command table
 * registered read port, one cycle latency
 */

`timescale 1ns/1ps

`include "i2c_init_settings.svh"

module init_rom import i2c_init_pkg::*; (
    input  logic      clk,
    input  rom_addr_t rom_addr,
    output rom_word_t rom_data
);

    // single-device sequence
    localparam rom_word_t ROM_TABLE [`I2C_INIT_ROM_DEPTH] = '{
        // first device, register 0x03 <= 0xa8
        rom_start_write(7'h20),
        rom_write_data(8'h03),
        rom_write_data(8'hA8),
        // settle time, 2**16 cycles
        rom_delay(4'd0),
        // register 0x01 <= 0x00, then release the bus
        rom_start_write(7'h20),
        rom_write_data(8'h01),
        rom_write_data(8'h00),
        CMD_SEND_STOP,
        // left over from the multi-device mode, skipped
        CMD_DATA_BLOCK,
        // second device, single byte
        rom_start_write(7'h21),
        rom_write_data(8'h5A),
        // end of run
        CMD_TERM_STOP
    };

    always_ff @(posedge clk) begin
        // past the end reads as the terminating stop
        if (rom_addr < `I2C_INIT_ROM_DEPTH) begin
            rom_data <= ROM_TABLE[rom_addr];
        end else begin
            rom_data <= CMD_TERM_STOP;
        end
    end

endmodule

// ==== rtl/init_sequencer.sv ====
/*
 * start detection, table walking and command decode
 * drives single-cycle strobes into the output stage and the delay timer
 */

`timescale 1ns/1ps

module init_sequencer import i2c_init_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  rom_word_t  rom_data,
    output rom_addr_t  rom_addr,
    input  logic       pending,
    input  logic       delay_active,
    output logic       set_address,
    output dev_addr_t  address,
    output logic       send_write,
    output byte_t      wdata,
    output logic       send_stop,
    output logic       load_delay,
    output delay_exp_t delay_exp,
    output logic       busy
);

    seq_state_t state;
    seq_state_t state_next;

    rom_addr_t ptr;
    rom_addr_t ptr_next;

    // set on a taken start, held until start drops
    logic start_flag;
    logic start_flag_next;

    // payload fields straight from the table word
    assign address   = rom_data[6:0];
    assign wdata     = rom_data[7:0];
    assign delay_exp = rom_data[3:0];

    // rom registers the next pointer, so rom_data tracks ptr
    assign rom_addr = ptr_next;

    always_comb begin
        state_next      = state;
        ptr_next        = ptr;
        start_flag_next = start_flag;

        set_address = 1'b0;
        send_write  = 1'b0;
        send_stop   = 1'b0;
        load_delay  = 1'b0;

        // stall while a command is in flight or a delay runs
        if (!pending && !delay_active) begin
            case (state)
                SEQ_IDLE: begin
                    if (start && !start_flag) begin
                        ptr_next        = '0;
                        start_flag_next = 1'b1;
                        state_next      = SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    if (rom_data[8]) begin
                        // data byte, command and data beat together
                        send_write = 1'b1;
                        ptr_next   = ptr + 1'b1;
                    end else if (rom_data[8:7] == OP_ADDR) begin
                        // address only, nothing goes out yet
                        set_address = 1'b1;
                        ptr_next    = ptr + 1'b1;
                    end else if (rom_data[8:4] == OP_DELAY) begin
                        load_delay = 1'b1;
                        ptr_next   = ptr + 1'b1;
                    end else if (rom_data == CMD_SEND_STOP) begin
                        send_stop = 1'b1;
                        ptr_next  = ptr + 1'b1;
                    end else if (rom_data == CMD_TERM_STOP) begin
                        // final stop, back to idle
                        send_stop  = 1'b1;
                        state_next = SEQ_IDLE;
                    end else begin
                        // unknown code, skip
                        ptr_next = ptr + 1'b1;
                    end
                end
                default: begin
                    state_next = SEQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SEQ_IDLE;
            ptr        <= '0;
            start_flag <= 1'b0;
            busy       <= 1'b0;
        end else begin
            state      <= state_next;
            ptr        <= ptr_next;
            // flag drops as soon as start is released
            start_flag <= start & start_flag_next;
            // one cycle behind the state
            busy       <= (state != SEQ_IDLE);
        end
    end

    // one action per table entry
    a_one_strobe: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({set_address, send_write, send_stop, load_delay})
    );

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/i2c_init_pkg.sv
rtl/init_rom.sv
rtl/delay_timer.sv
rtl/i2c_cmd_stage.sv
rtl/init_sequencer.sv
rtl/i2c_init.sv
tb/tb_i2c_init.sv

// ==== tb/tb_i2c_init.sv ====
/*
 * testbench for the i2c initialiser
 * clock, reset, random ready, reference table model, stream monitor, tests
 */

`timescale 1ns/1ps

`include "i2c_init_settings.svh"

module tb_i2c_init import i2c_init_pkg::*; ();

    // expected beat for one command issued by the table
    typedef struct packed {
        i2c_cmd_t cmd;
        byte_t    data;
        logic     has_data;
    } beat_t;

    localparam int unsigned DELAY_MIN    = 1 << `I2C_INIT_DELAY_BASE;
    localparam int unsigned RUN_TIMEOUT  = 4 * DELAY_MIN;
    localparam int unsigned BUSY_TIMEOUT = 50;
    localparam int unsigned IDLE_CYCLES  = 20;
    localparam int unsigned HOLD_CYCLES  = 200;
    // table entries that put a command on the stream
    localparam int ISSUE_IDX [7] = '{1, 2, 5, 6, 7, 10, 11};

    logic     clk;
    logic     rst;
    logic     start;
    i2c_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    byte_t    data;
    logic     data_valid;
    logic     data_ready;
    logic     busy;

    integer      seed = 32'h61f0_ac1c;
    logic [31:0] rnd;

    // expectations and monitor state
    i2c_cmd_t    exp_cmd [$];
    byte_t       exp_data [$];
    int unsigned cmd_times [$];
    int unsigned cycle = 0;
    logic        prev_cmd_stall = 1'b0;
    logic        prev_data_stall = 1'b0;
    i2c_cmd_t    prev_cmd;
    byte_t       prev_data;
    int unsigned mon_errs = 0;
    int unsigned hold_errs = 0;
    int unsigned t1_errs = 0;
    int unsigned t2_errs = 0;
    int unsigned t3_errs = 0;
    int unsigned t4_errs = 0;
    int unsigned t5_errs = 0;
    int unsigned snap_mon;
    int unsigned snap_hold;
    int unsigned total;

    i2c_init u_i2c_init (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .data       (data),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // random back-pressure on both streams
    always @(posedge clk) begin
        rnd = $random(seed);
        cmd_ready  <= rnd[0];
        data_ready <= rnd[1];
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int unsigned errs);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            errs++;
        end
    endtask

    // fields: address, start write stop, data byte, data follows
    function automatic beat_t ref_beat(input int tbl_idx);
        case (tbl_idx)
            // first write after a start-write entry carries start
            1:       return {7'h20, 3'b110, 8'h03, 1'b1};
            2:       return {7'h20, 3'b010, 8'hA8, 1'b1};
            5:       return {7'h20, 3'b110, 8'h01, 1'b1};
            6:       return {7'h20, 3'b010, 8'h00, 1'b1};
            // stop keeps the last address
            7:       return {7'h20, 3'b001, 8'h00, 1'b0};
            10:      return {7'h21, 3'b110, 8'h5A, 1'b1};
            11:      return {7'h21, 3'b001, 8'h00, 1'b0};
            default: return '0;
        endcase
    endfunction

    task automatic arm_run();
        beat_t b;
        exp_cmd.delete();
        exp_data.delete();
        cmd_times.delete();
        foreach (ISSUE_IDX[i]) begin
            b = ref_beat(ISSUE_IDX[i]);
            exp_cmd.push_back(b.cmd);
            if (b.has_data) begin
                exp_data.push_back(b.data);
            end
        end
    endtask

    // sampled before the edge updates anything
    always @(posedge clk) begin
        cycle++;
        if (!rst) begin
            // stalled beats must hold
            if (prev_cmd_stall) begin
                check_value("cmd_valid", cmd_valid, 1'b1, hold_errs);
                check_value("cmd", cmd, prev_cmd, hold_errs);
            end
            if (prev_data_stall) begin
                check_value("data_valid", data_valid, 1'b1, hold_errs);
                check_value("data", data, prev_data, hold_errs);
            end
            if (cmd_valid && cmd_ready) begin
                if (exp_cmd.size() == 0) begin
                    $display("unexpected command transfer, cmd 0x%0h", cmd);
                    mon_errs++;
                end else begin
                    // final stop may go out after busy drops
                    if (exp_cmd.size() > 1) begin
                        check_value("busy", busy, 1'b1, mon_errs);
                    end
                    check_value("cmd", cmd, exp_cmd.pop_front(), mon_errs);
                    cmd_times.push_back(cycle);
                end
            end
            if (data_valid && data_ready) begin
                if (exp_data.size() == 0) begin
                    $display("unexpected data transfer, data 0x%0h", data);
                    mon_errs++;
                end else begin
                    check_value("data", data, exp_data.pop_front(), mon_errs);
                end
            end
        end
        prev_cmd_stall  = !rst && cmd_valid && !cmd_ready;
        prev_data_stall = !rst && data_valid && !data_ready;
        prev_cmd        = cmd;
        prev_data       = data;
    end

    task automatic wait_run_end(inout int unsigned errs);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while ((exp_cmd.size() != 0 || exp_data.size() != 0 || busy) && n < RUN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= RUN_TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", RUN_TIMEOUT);
            errs++;
        end
    endtask

    task automatic wait_busy_high(inout int unsigned errs);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (!busy && n < BUSY_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= BUSY_TIMEOUT) begin
            $display("timeout: busy did not rise after start");
            errs++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int unsigned errs);
        $display("test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "ok" : "FAILED", errs);
    endtask

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        cmd_ready  = 1'b0;
        data_ready = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // quiet outputs before any start
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("cmd_valid", cmd_valid, 1'b0, t1_errs);
            check_value("data_valid", data_valid, 1'b0, t1_errs);
            check_value("busy", busy, 1'b0, t1_errs);
        end
        report_test(1, "idle after reset", t1_errs);

        // one start pulse, whole table
        arm_run();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_run_end(t2_errs);
        report_test(2, "command and data order", t2_errs + mon_errs);
        check_value("outstanding cmds", exp_cmd.size(), 0, t3_errs);
        check_value("outstanding data", exp_data.size(), 0, t3_errs);
        report_test(3, "hold under back-pressure", t3_errs + hold_errs);

        // settle delay between 2nd and 3rd command
        if (cmd_times.size() < 3) begin
            $display("delay not measured, only %0d command transfers", cmd_times.size());
            t4_errs++;
        end else if (cmd_times[2] - cmd_times[1] < DELAY_MIN) begin
            $display("delay too short, %0d cycles", cmd_times[2] - cmd_times[1]);
            t4_errs++;
        end
        report_test(4, "table delay", t4_errs);

        // start held high through and after the run
        snap_mon  = mon_errs;
        snap_hold = hold_errs;
        arm_run();
        @(posedge clk);
        start <= 1'b1;
        wait_busy_high(t5_errs);
        wait_run_end(t5_errs);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_value("cmd_valid", cmd_valid, 1'b0, t5_errs);
            check_value("busy", busy, 1'b0, t5_errs);
        end
        // release and retrigger
        @(posedge clk);
        start <= 1'b0;
        repeat (2) @(posedge clk);
        arm_run();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_busy_high(t5_errs);
        wait_run_end(t5_errs);
        report_test(5, "busy and retrigger",
                    t5_errs + (mon_errs - snap_mon) + (hold_errs - snap_hold));

        total = t1_errs + t2_errs + t3_errs + t4_errs + t5_errs + mon_errs + hold_errs;
        $display("tests run: 5, errors: %0d", total);
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
